/* hw/mips_pkg.sv */
/* shared encodings, sizes and stage payload structs for the four-stage core
   every RTL file refers to these by scoped name */
`default_nettype none

package mips_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 64; // word addressed by alu_result[7:2]

    // major opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2B;

    // r-type funct field
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2A;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg; // writeback takes load data
        logic alu_src;    // b operand is the immediate
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        alu_op_e               alu_op;
        logic [5:0]            funct;
        logic [word_w-1:0]     rs_val;
        logic [word_w-1:0]     rt_val;
        logic [word_w-1:0]     imm;  // already sign extended
        logic [reg_addr_w-1:0] dest;
    } ex_bundle_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [word_w-1:0]     alu_result;
        logic [word_w-1:0]     store_data;
        logic [reg_addr_w-1:0] dest;
    } mem_bundle_t;

    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [word_w-1:0]     data;
    } wb_write_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
/* 32 x 32 register file with two operand reads, one debug read and one write
   operand reads bypass the write in flight, register 0 stays zero */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  logic [mips_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_w-1:0] rt_addr,
    output logic [mips_pkg::word_w-1:0]     rs_val,
    output logic [mips_pkg::word_w-1:0]     rt_val,
    input  mips_pkg::wb_write_t             wb,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [mips_pkg::word_w-1:0]     dbg_data
);
    logic [mips_pkg::word_w-1:0] regs [1 << mips_pkg::reg_addr_w];

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < (1 << mips_pkg::reg_addr_w); i++)
                regs[i] <= '0;
        end
        else if (wb.en && wb.addr != '0)
            regs[wb.addr] <= wb.data; // r0 never written
    end

    // write-through covers the writeback distance
    assign rs_val = (rs_addr == '0) ? '0 :
                    (wb.en && wb.addr == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_val = (rt_addr == '0) ? '0 :
                    (wb.en && wb.addr == rt_addr) ? wb.data : regs[rt_addr];

    assign dbg_data = regs[dbg_addr]; // stored state only

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
/* decode register fed by the instruction stream, control decode, register read
   stalls against pending writes in execute and memory and inserts a bubble */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  logic                            instr_valid,
    input  logic [mips_pkg::word_w-1:0]     instr,
    output logic                            instr_ready,
    input  mips_pkg::wb_write_t             wb,
    input  mips_pkg::wb_write_t             ex_dest_hit,
    input  mips_pkg::wb_write_t             mem_dest_hit,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [mips_pkg::word_w-1:0]     dbg_data,
    output mips_pkg::ex_bundle_t            to_ex,
    output logic                            busy_d
);
    logic                            d_valid;
    logic [mips_pkg::word_w-1:0]     d_instr;
    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    logic [mips_pkg::reg_addr_w-1:0] rs, rt, rd;
    logic [mips_pkg::word_w-1:0]     rs_val, rt_val;
    mips_pkg::ctrl_t                 ctrl;
    mips_pkg::alu_op_e               alu_op;
    logic                            supported;
    logic                            uses_rt;
    logic                            rs_hazard, rt_hazard;
    logic                            stall;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_valid <= 1'b0;
        else if (!stall)
        begin
            d_valid <= instr_valid;
            d_instr <= instr;
        end
    end

    assign opcode = d_instr[31:26];
    assign rs     = d_instr[25:21];
    assign rt     = d_instr[20:16];
    assign rd     = d_instr[15:11];
    assign funct  = d_instr[5:0];

    // main control and r-type alu operation
    always_comb
    begin
        ctrl      = '0;
        alu_op    = mips_pkg::alu_add;
        supported = 1'b1;
        uses_rt   = 1'b0;
        case (opcode)
            mips_pkg::op_rtype:
            begin
                ctrl.reg_write = 1'b1;
                uses_rt        = 1'b1;
                case (funct)
                    mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_slt: alu_op = mips_pkg::alu_slt;
                    default:          supported = 1'b0;
                endcase
            end
            mips_pkg::op_addi:
                ctrl = '{reg_write: 1'b1, mem_read: 1'b0, mem_write: 1'b0,
                         mem_to_reg: 1'b0, alu_src: 1'b1};
            mips_pkg::op_lw:
                ctrl = '{reg_write: 1'b1, mem_read: 1'b1, mem_write: 1'b0,
                         mem_to_reg: 1'b1, alu_src: 1'b1};
            mips_pkg::op_sw:
            begin
                ctrl    = '{reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b1,
                            mem_to_reg: 1'b0, alu_src: 1'b1};
                uses_rt = 1'b1; // store data
            end
            default:
                supported = 1'b0;
        endcase
    end

    assign rs_hazard = rs != '0 &&
        ((ex_dest_hit.en && ex_dest_hit.addr == rs) || (mem_dest_hit.en && mem_dest_hit.addr == rs));
    assign rt_hazard = uses_rt && rt != '0 &&
        ((ex_dest_hit.en && ex_dest_hit.addr == rt) || (mem_dest_hit.en && mem_dest_hit.addr == rt));
    assign stall       = d_valid && supported && (rs_hazard || rt_hazard);
    assign instr_ready = !stall;

    reg_file rf0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs),
        .rt_addr   (rt),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .wb        (wb),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    assign to_ex.valid  = d_valid && supported && !stall; // bubble while stalled
    assign to_ex.ctrl   = ctrl;
    assign to_ex.alu_op = alu_op;
    assign to_ex.funct  = funct;
    assign to_ex.rs_val = rs_val;
    assign to_ex.rt_val = rt_val;
    assign to_ex.imm    = {{(mips_pkg::word_w - 16){d_instr[15]}}, d_instr[15:0]};
    assign to_ex.dest   = (opcode == mips_pkg::op_rtype) ? rd : rt;

    assign busy_d = d_valid;

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
/* execute register, operand select and ALU
   exposes its pending register write for the decode hazard check */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  mips_pkg::ex_bundle_t  from_d,
    output mips_pkg::mem_bundle_t to_mem,
    output mips_pkg::wb_write_t   pending
);
    mips_pkg::ex_bundle_t        ex_q;
    logic [mips_pkg::word_w-1:0] b_operand;
    logic [mips_pkg::word_w-1:0] alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_q.valid <= 1'b0;
            ex_q.ctrl  <= '0;
        end
        else
            ex_q <= from_d;
    end

    assign b_operand = ex_q.ctrl.alu_src ? ex_q.imm : ex_q.rt_val;

    always_comb
    begin
        case (ex_q.alu_op)
            mips_pkg::alu_sub: alu_result = ex_q.rs_val - b_operand;
            mips_pkg::alu_and: alu_result = ex_q.rs_val & b_operand;
            mips_pkg::alu_or:  alu_result = ex_q.rs_val | b_operand;
            mips_pkg::alu_slt: alu_result = {{(mips_pkg::word_w - 1){1'b0}},
                                             $signed(ex_q.rs_val) < $signed(b_operand)};
            default:           alu_result = ex_q.rs_val + b_operand;
        endcase
    end

    assign to_mem = '{valid: ex_q.valid, ctrl: ex_q.ctrl, alu_result: alu_result,
                      store_data: ex_q.rt_val, dest: ex_q.dest};

    assign pending = '{en: ex_q.valid && ex_q.ctrl.reg_write, addr: ex_q.dest,
                       data: alu_result};

endmodule

`default_nettype wire

/* hw/memory_writeback.sv */
/* memory register with data memory, then the writeback register
   stores write on the edge that ends the memory cycle, loads read combinationally */
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  mips_pkg::mem_bundle_t from_ex,
    output mips_pkg::wb_write_t   wb,
    output mips_pkg::wb_write_t   pending,
    output logic                  busy_mw
);
    localparam int addr_w = $clog2(mips_pkg::dmem_words);

    mips_pkg::mem_bundle_t       mem_q;
    mips_pkg::wb_write_t         wb_q;
    logic                        wb_valid; // any instruction, stores included
    logic [mips_pkg::word_w-1:0] dmem [mips_pkg::dmem_words];
    logic [addr_w-1:0]           dmem_addr;
    logic [mips_pkg::word_w-1:0] load_data;
    logic [mips_pkg::word_w-1:0] result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_q.valid <= 1'b0;
            mem_q.ctrl  <= '0;
        end
        else
            mem_q <= from_ex;
    end

    assign dmem_addr = mem_q.alu_result[addr_w+1:2];

    always_ff @(posedge SYS_clk)
    begin
        if (mem_q.valid && mem_q.ctrl.mem_write)
            dmem[dmem_addr] <= mem_q.store_data;
    end

    assign load_data = mem_q.ctrl.mem_read ? dmem[dmem_addr] : '0;
    assign result    = mem_q.ctrl.mem_to_reg ? load_data : mem_q.alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_valid <= 1'b0;
            wb_q.en  <= 1'b0;
        end
        else
        begin
            wb_valid  <= mem_q.valid;
            wb_q.en   <= mem_q.valid && mem_q.ctrl.reg_write;
            wb_q.addr <= mem_q.dest;
            wb_q.data <= result;
        end
    end

    assign wb      = wb_q;
    assign pending = '{en: mem_q.valid && mem_q.ctrl.reg_write, addr: mem_q.dest, data: result};
    assign busy_mw = mem_q.valid || wb_valid;

endmodule

`default_nettype wire

/* hw/mips_core.sv */
/* top of the core, connects decode, execute and memory/writeback
   instructions come in on a valid/ready stream, busy covers all pending effects */
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  logic                            SYS_clk,
    input  logic                            SYS_reset,
    input  logic                            instr_valid,
    input  logic [mips_pkg::word_w-1:0]     instr,
    output logic                            instr_ready,
    input  logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [mips_pkg::word_w-1:0]     dbg_data,
    output logic                            busy
);
    mips_pkg::ex_bundle_t  d_to_ex;
    mips_pkg::mem_bundle_t ex_to_mem;
    mips_pkg::wb_write_t   wb_w;
    mips_pkg::wb_write_t   ex_pending;
    mips_pkg::wb_write_t   mem_pending;
    logic                  busy_d;
    logic                  busy_mw;

    decode_stage decode0 (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .wb           (wb_w),
        .ex_dest_hit  (ex_pending),
        .mem_dest_hit (mem_pending),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data),
        .to_ex        (d_to_ex),
        .busy_d       (busy_d)
    );

    execute_stage execute0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .from_d    (d_to_ex),
        .to_mem    (ex_to_mem),
        .pending   (ex_pending)
    );

    memory_writeback memwb0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .from_ex   (ex_to_mem),
        .wb        (wb_w),
        .pending   (mem_pending),
        .busy_mw   (busy_mw)
    );

    assign busy = busy_d || ex_to_mem.valid || busy_mw; // execute register valid

endmodule

`default_nettype wire

/* bench/mips_core_assertions.sv */
/* concurrent checks on the stream handshake, busy and the debug port
   bound into every mips_core instance */
`timescale 1ns/1ps
`default_nettype none

module mips_core_assertions (
    input logic                            SYS_clk,
    input logic                            SYS_reset,
    input logic                            instr_ready,
    input logic                            busy,
    input logic [mips_pkg::reg_addr_w-1:0] dbg_addr,
    input logic [mips_pkg::word_w-1:0]     dbg_data
);
    ready_after_reset: assert property (@(posedge SYS_clk) $fell(SYS_reset) |-> instr_ready)
        else $error("instr_ready low in the first cycle after reset");

    idle_means_ready: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !busy |-> instr_ready)
        else $error("instr_ready low while the core is idle");

    r0_reads_zero: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        dbg_addr == '0 |-> dbg_data == '0)
        else $error("register 0 read nonzero on the debug port");

endmodule

bind mips_core mips_core_assertions asrt0 (
    .SYS_clk     (SYS_clk),
    .SYS_reset   (SYS_reset),
    .instr_ready (instr_ready),
    .busy        (busy),
    .dbg_addr    (dbg_addr),
    .dbg_data    (dbg_data)
);

`default_nettype wire

/* bench/mips_core_tb.sv */
/* directed testbench for the four-stage core, driving the instruction stream
   keeps a register and memory model and compares it through the debug port */
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam int wait_limit = 20; // cycles per wait

    logic        SYS_clk = 1'b0;
    logic        SYS_reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic        busy;

    logic [31:0] model_regs [32];
    logic [31:0] model_mem [64];
    logic [31:0] lcg_state;
    int          error_count;

    mips_core dut0 (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .busy        (busy)
    );

    always #2 SYS_clk = ~SYS_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sign_ext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // reference results for the five r-type operations
    function automatic logic [31:0] alu_model(input logic [5:0] fn, input logic [31:0] a,
                                              input logic [31:0] b);
        case (fn)
            mips_pkg::fn_sub: return a - b;
            mips_pkg::fn_and: return a & b;
            mips_pkg::fn_or:  return a | b;
            mips_pkg::fn_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return a + b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            error_count++;
            $display("mismatch %s got 0x%08h expected 0x%08h", name, got, expected);
            $display("Result: FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("gave up waiting for %s after %0d cycles", what, wait_limit);
        $display("Result: FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic send_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        instr_valid <= 1'b1;
        instr       <= word;
        @(negedge SYS_clk);
        while (!instr_ready && waited < wait_limit)
        begin
            waited++;
            @(negedge SYS_clk);
        end
        if (!instr_ready)
            report_timeout("instr_ready");
        @(posedge SYS_clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        instr_valid <= 1'b0;
        @(negedge SYS_clk);
        while (busy && waited < wait_limit)
        begin
            waited++;
            @(negedge SYS_clk);
        end
        if (busy)
            report_timeout("busy to fall");
        @(posedge SYS_clk);
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [31:0] expected);
        dbg_addr <= addr;
        @(negedge SYS_clk);
        check_value($sformatf("dbg_data[r%0d]", addr), dbg_data, expected);
        @(posedge SYS_clk);
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++)
            read_reg(5'(i), model_regs[i]);
    endtask

    task automatic do_addi(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        send_instr(encode_i(mips_pkg::op_addi, rs, rt, imm));
        if (rt != 5'd0)
            model_regs[rt] = model_regs[rs] + sign_ext(imm);
    endtask

    task automatic do_r(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
                        input logic [4:0] rt);
        send_instr(encode_r(rs, rt, rd, fn));
        if (rd != 5'd0)
            model_regs[rd] = alu_model(fn, model_regs[rs], model_regs[rt]);
    endtask

    task automatic do_sw(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs] + sign_ext(imm);
        send_instr(encode_i(mips_pkg::op_sw, rs, rt, imm));
        model_mem[addr[7:2]] = model_regs[rt];
    endtask

    task automatic do_lw(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs] + sign_ext(imm);
        send_instr(encode_i(mips_pkg::op_lw, rs, rt, imm));
        if (rt != 5'd0)
            model_regs[rt] = model_mem[addr[7:2]];
    endtask

    // idle core right after reset
    task automatic test_reset_state();
        @(negedge SYS_clk);
        check_value("busy", busy, 32'd0);
        check_value("instr_ready", instr_ready, 32'd1);
        @(posedge SYS_clk);
    endtask

    task automatic test_immediate_loads();
        logic [31:0] rnd;
        for (int r = 1; r <= 8; r++)
        begin
            rnd = lcg_next();
            do_addi(5'(r), 5'd0, rnd[15:0]);
        end
        drain();
        check_regs();
    endtask

    task automatic test_independent_ops();
        do_r(mips_pkg::fn_add, 5'd9, 5'd1, 5'd2);
        do_r(mips_pkg::fn_sub, 5'd10, 5'd3, 5'd4);
        do_r(mips_pkg::fn_and, 5'd11, 5'd5, 5'd6);
        do_r(mips_pkg::fn_or, 5'd12, 5'd7, 5'd8);
        do_r(mips_pkg::fn_slt, 5'd13, 5'd1, 5'd2);
        do_r(mips_pkg::fn_slt, 5'd14, 5'd2, 5'd1); // opposite order
        drain();
        check_regs();
    endtask

    task automatic test_dependence_chains();
        do_addi(5'd15, 5'd1, 16'h0005); // distance 1
        do_r(mips_pkg::fn_add, 5'd16, 5'd15, 5'd2);
        do_r(mips_pkg::fn_sub, 5'd17, 5'd16, 5'd15);
        do_r(mips_pkg::fn_slt, 5'd18, 5'd17, 5'd16);
        do_addi(5'd19, 5'd3, 16'hFFF0); // distance 2
        do_addi(5'd20, 5'd4, 16'h0011);
        do_r(mips_pkg::fn_or, 5'd21, 5'd19, 5'd5);
        do_r(mips_pkg::fn_and, 5'd22, 5'd20, 5'd21);
        do_addi(5'd23, 5'd6, 16'h0100); // distance 3
        do_addi(5'd24, 5'd0, 16'h0003);
        do_addi(5'd25, 5'd0, 16'h0009);
        do_r(mips_pkg::fn_add, 5'd26, 5'd23, 5'd24);
        drain();
        check_regs();
    endtask

    task automatic test_store_load();
        do_sw(5'd1, 5'd0, 16'h0010);
        do_sw(5'd2, 5'd0, 16'h0024);
        do_sw(5'd3, 5'd0, 16'h0038);
        do_lw(5'd27, 5'd0, 16'h0024);
        do_sw(5'd4, 5'd0, 16'h004C);
        do_lw(5'd28, 5'd0, 16'h004C); // right behind its store
        do_lw(5'd29, 5'd0, 16'h0010);
        do_r(mips_pkg::fn_add, 5'd30, 5'd29, 5'd1); // load use
        do_lw(5'd31, 5'd0, 16'h0038);
        do_addi(5'd9, 5'd0, 16'h7ABC);
        do_sw(5'd9, 5'd0, 16'h0060); // store data still in flight
        do_lw(5'd10, 5'd0, 16'h0060);
        drain();
        check_regs();
    endtask

    task automatic test_reg0_and_unsupported();
        do_addi(5'd0, 5'd1, 16'h0055);
        do_r(mips_pkg::fn_add, 5'd0, 5'd1, 5'd2);
        send_instr(encode_i(6'h3F, 5'd1, 5'd5, 16'h1234)); // unknown opcode
        send_instr(encode_r(5'd1, 5'd2, 5'd6, 6'h21));     // unknown funct
        send_instr(encode_i(6'h04, 5'd1, 5'd7, 16'h0002)); // branch, not supported
        drain();
        check_regs();
    endtask

    initial
    begin
        SYS_reset   <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        dbg_addr    <= '0;
        lcg_state   = 32'h7310;
        error_count = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        test_reset_state();
        test_immediate_loads();
        test_independent_ops();
        test_dependence_chains();
        test_store_load();
        test_reg0_and_unsupported();
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/mips_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/mips_core.sv
bench/mips_core_assertions.sv
bench/mips_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run it and judge the log
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mips_core_tb --Mdir obj_dir -o mips_core_sim \
    -f sim.f > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status, see $build_log"
    exit 1
fi

./obj_dir/mips_core_sim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"

if grep -q "Result: FAILED" "$sim_log"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation finished without failure"
exit 0
